// File: hps_pkg.sv
`default_nettype none

package hps_pkg;

	// bus and register widths
	localparam int IO_W        = 16;
	localparam int CNT_W       = 4;
	localparam int JOY_W       = 32;
	localparam int STATUS_W    = 64;
	localparam int FILE_ADDR_W = 27;

	typedef logic [IO_W-1:0]     io_word_t;
	typedef logic [CNT_W-1:0]    byte_cnt_t;
	typedef logic [JOY_W-1:0]    joy_t;
	typedef logic [STATUS_W-1:0] status_t;

	// one word event as seen by the function blocks
	typedef struct packed {
		io_word_t  cmd;
		byte_cnt_t cnt;
		logic      first;
		logic      data;
		logic      last;
		io_word_t  din;
	} hps_word_t;

	////////////////////////////////////////
	// command codes
	localparam io_word_t CMD_CFG         = 16'h0001;
	localparam io_word_t CMD_JOY0        = 16'h0002;
	localparam io_word_t CMD_JOY1        = 16'h0003;
	localparam io_word_t CMD_KBD         = 16'h0005;
	localparam io_word_t CMD_STATUS      = 16'h001E;
	localparam io_word_t CMD_STATUS_REQ  = 16'h0029;
	localparam io_word_t CMD_FILE_TX     = 16'h0053;
	localparam io_word_t CMD_FILE_TX_DAT = 16'h0054;
	localparam io_word_t CMD_FILE_INDEX  = 16'h0055;
	localparam io_word_t CMD_FILE_INFO   = 16'h0056;

	// upper byte of a keyboard word that the host wants ignored
	localparam logic [7:0] KEY_SKIP_BYTE = 8'hFF;

endpackage

`default_nettype wire

// File: hps_cmd_frame.sv
`default_nettype none

module hps_cmd_frame
	import hps_pkg::*;
(
	input  logic      clk_sys,
	input  logic      reset,
	input  logic      enable,
	input  logic      strobe,
	input  io_word_t  din,
	output hps_word_t word
);

	io_word_t  cmd_r;
	byte_cnt_t cnt_r;
	logic      has_cmd;
	logic      take;

	assign take = enable & strobe;

	// word events, combinational from the strobe
	always_comb begin
		word.first = take & ~has_cmd;
		word.data  = take & has_cmd;
		// enable low after a frame that carried a command
		word.last  = ~enable & has_cmd;
		// on the command strobe itself the code is still on the bus
		word.cmd   = has_cmd ? cmd_r : din;
		word.cnt   = cnt_r;
		word.din   = din;
	end

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			cmd_r   <= '0;
			cnt_r   <= '0;
			has_cmd <= 1'b0;
		end else if (!enable) begin
			cmd_r   <= '0;
			cnt_r   <= '0;
			has_cmd <= 1'b0;
		end else if (take) begin
			if (!has_cmd) begin
				cmd_r   <= din;
				cnt_r   <= 4'd1;
				has_cmd <= 1'b1;
			end else if (cnt_r != 4'hF) begin
				// saturate so long frames keep the last position
				cnt_r <= cnt_r + 4'd1;
			end
		end
	end

endmodule

`default_nettype wire

// File: hps_input_regs.sv
`default_nettype none

module hps_input_regs
	import hps_pkg::*;
(
	input  logic      clk_sys,
	input  logic      reset,
	input  hps_word_t word,
	input  status_t   status_in,
	input  logic      status_set,
	output joy_t      joystick_0,
	output joy_t      joystick_1,
	output logic [1:0] buttons,
	output logic      forced_scandoubler,
	output logic      direct_video,
	output status_t   status,
	output io_word_t  io_dout
);

	io_word_t  cfg;
	status_t   status_req;
	logic [3:0] req_cnt;
	logic      status_set_d;
	io_word_t  rd_val;

	assign buttons            = cfg[1:0];
	assign forced_scandoubler = cfg[4];
	assign direct_video       = cfg[10];

	////////////////////////////////////////
	// host writes
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			cfg        <= '0;
			joystick_0 <= '0;
			joystick_1 <= '0;
			status     <= '0;
		end else if (word.data) begin
			case (word.cmd)
				CMD_CFG: cfg <= word.din;
				CMD_JOY0: begin
					if (word.cnt == 4'd1)
						joystick_0[15:0] <= word.din;
					else
						joystick_0[31:16] <= word.din;
				end
				CMD_JOY1: begin
					if (word.cnt == 4'd1)
						joystick_1[15:0] <= word.din;
					else
						joystick_1[31:16] <= word.din;
				end
				CMD_STATUS: begin
					// quarters arrive lowest first
					case (word.cnt)
						4'd1: status[15:0]  <= word.din;
						4'd2: status[31:16] <= word.din;
						4'd3: status[47:32] <= word.din;
						4'd4: status[63:48] <= word.din;
						default: ;
					endcase
				end
				default: ;
			endcase
		end
	end

	////////////////////////////////////////
	// core side status-set request
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			status_set_d <= 1'b0;
			req_cnt      <= '0;
		end else begin
			status_set_d <= status_set;
			if (status_set && !status_set_d)
				req_cnt <= req_cnt + 4'd1;
		end
	end

	always_ff @(posedge clk_sys) begin
		if (status_set && !status_set_d)
			status_req <= status_in;
	end

	////////////////////////////////////////
	// read-back
	always_comb begin
		rd_val = '0;
		if (word.cmd == CMD_STATUS_REQ) begin
			if (word.first) begin
				rd_val = {8'h00, 4'hA, req_cnt};
			end else begin
				case (word.cnt)
					4'd1: rd_val = status_req[15:0];
					4'd2: rd_val = status_req[31:16];
					4'd3: rd_val = status_req[47:32];
					4'd4: rd_val = status_req[63:48];
					default: rd_val = '0;
				endcase
			end
		end
	end

	always_ff @(posedge clk_sys) begin
		if (reset)
			io_dout <= '0;
		else if (word.first || word.data)
			io_dout <= rd_val;
		else if (word.last)
			io_dout <= '0;
	end

endmodule

`default_nettype wire

// File: hps_key_decode.sv
`default_nettype none

module hps_key_decode
	import hps_pkg::*;
(
	input  logic        clk_sys,
	input  logic        reset,
	input  hps_word_t   word,
	output logic [10:0] ps2_key
);

	logic [31:0] raw;
	logic        skip;
	logic        pressed;
	logic        extended;
	logic [9:0]  key_code;

	// break codes carry F0 just before the key byte
	assign pressed  = (raw[15:8] != 8'hF0);
	assign extended = pressed ? (raw[15:8] == 8'hE0) : (raw[23:16] == 8'hE0);

	always_comb begin
		key_code = {pressed, extended, raw[7:0]};
		case (raw)
			// print screen make
			32'hE012E07C: key_code = 10'h37C;
			// print screen break
			32'h7CE0F012: key_code = 10'h17C;
			// pause make
			32'hF014F077: key_code = 10'h377;
			default: ;
		endcase
	end

	////////////////////////////////////////
	// byte collection
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			raw  <= '0;
			skip <= 1'b0;
		end else if (word.cmd == CMD_KBD) begin
			if (word.first) begin
				raw  <= '0;
				skip <= 1'b0;
			end else if (word.data) begin
				if (word.din[15:8] == KEY_SKIP_BYTE)
					skip <= 1'b1;
				else if (!skip)
					raw <= {raw[23:0], word.din[7:0]};
			end
		end
	end

	// event is published when the frame closes
	always_ff @(posedge clk_sys) begin
		if (reset)
			ps2_key <= '0;
		else if (word.last && word.cmd == CMD_KBD && !skip)
			ps2_key <= {~ps2_key[10], key_code};
	end

endmodule

`default_nettype wire

// File: hps_file_loader.sv
`default_nettype none

module hps_file_loader
	import hps_pkg::*;
#(
	parameter int WIDE = 0
)
(
	input  logic                   clk_sys,
	input  logic                   reset,
	input  hps_word_t              word,
	output logic                   ioctl_download,
	output logic [7:0]             ioctl_index,
	output logic [31:0]            ioctl_file_ext,
	output logic [FILE_ADDR_W-1:0] ioctl_addr,
	output logic [15:0]            ioctl_dout,
	output logic                   ioctl_wr
);

	localparam logic [FILE_ADDR_W-1:0] ADDR_STEP = (WIDE != 0) ? 27'd2 : 27'd1;

	logic [FILE_ADDR_W-1:0] addr;
	logic                   wr_pend;
	logic [15:0]            wr_data;

	// 8-bit mode only carries the low byte
	assign wr_data = (WIDE != 0) ? word.din : {8'h00, word.din[7:0]};

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			ioctl_download <= 1'b0;
			ioctl_index    <= '0;
			ioctl_file_ext <= '0;
			ioctl_addr     <= '0;
			ioctl_dout     <= '0;
			ioctl_wr       <= 1'b0;
			wr_pend        <= 1'b0;
			addr           <= '0;
		end else begin
			// write strobe trails the data load by one stage
			ioctl_wr <= wr_pend;
			wr_pend  <= 1'b0;

			if (word.data) begin
				case (word.cmd)
					CMD_FILE_INFO: begin
						if (word.cnt == 4'd1)
							ioctl_file_ext[31:16] <= word.din;
						else if (word.cnt == 4'd2)
							ioctl_file_ext[15:0] <= word.din;
					end
					CMD_FILE_INDEX: ioctl_index <= word.din[7:0];
					CMD_FILE_TX: begin
						if (word.din[7:0] != 8'h00) begin
							addr           <= '0;
							ioctl_download <= 1'b1;
						end else begin
							// leave the final length on the address
							ioctl_addr     <= addr;
							ioctl_download <= 1'b0;
						end
					end
					CMD_FILE_TX_DAT: begin
						ioctl_addr <= addr;
						ioctl_dout <= wr_data;
						wr_pend    <= 1'b1;
						addr       <= addr + ADDR_STEP;
					end
					default: ;
				endcase
			end
		end
	end

endmodule

`default_nettype wire

// File: hps_io.sv
`default_nettype none

module hps_io
	import hps_pkg::*;
#(
	parameter int WIDE = 0
)
(
	input  logic                   clk_sys,
	input  logic                   reset,
	input  logic                   io_enable,
	input  logic                   fp_enable,
	input  logic                   io_strobe,
	input  io_word_t               io_din,
	output io_word_t               io_dout,
	input  status_t                status_in,
	input  logic                   status_set,
	output joy_t                   joystick_0,
	output joy_t                   joystick_1,
	output logic [1:0]             buttons,
	output logic                   forced_scandoubler,
	output logic                   direct_video,
	output status_t                status,
	output logic [10:0]            ps2_key,
	output logic                   ioctl_download,
	output logic [7:0]             ioctl_index,
	output logic [31:0]            ioctl_file_ext,
	output logic [FILE_ADDR_W-1:0] ioctl_addr,
	output logic [15:0]            ioctl_dout,
	output logic                   ioctl_wr
);

	hps_word_t io_word;
	hps_word_t fp_word;

	////////////////////////////////////////
	// frame trackers, one per enable
	hps_cmd_frame u_io_frame (
		.clk_sys (clk_sys),
		.reset   (reset),
		.enable  (io_enable),
		.strobe  (io_strobe),
		.din     (io_din),
		.word    (io_word)
	);

	hps_cmd_frame u_fp_frame (
		.clk_sys (clk_sys),
		.reset   (reset),
		.enable  (fp_enable),
		.strobe  (io_strobe),
		.din     (io_din),
		.word    (fp_word)
	);

	////////////////////////////////////////
	// function blocks
	hps_input_regs u_input_regs (
		.clk_sys            (clk_sys),
		.reset              (reset),
		.word               (io_word),
		.status_in          (status_in),
		.status_set         (status_set),
		.joystick_0         (joystick_0),
		.joystick_1         (joystick_1),
		.buttons            (buttons),
		.forced_scandoubler (forced_scandoubler),
		.direct_video       (direct_video),
		.status             (status),
		.io_dout            (io_dout)
	);

	hps_key_decode u_key_decode (
		.clk_sys (clk_sys),
		.reset   (reset),
		.word    (io_word),
		.ps2_key (ps2_key)
	);

	hps_file_loader #(
		.WIDE (WIDE)
	) u_file_loader (
		.clk_sys        (clk_sys),
		.reset          (reset),
		.word           (fp_word),
		.ioctl_download (ioctl_download),
		.ioctl_index    (ioctl_index),
		.ioctl_file_ext (ioctl_file_ext),
		.ioctl_addr     (ioctl_addr),
		.ioctl_dout     (ioctl_dout),
		.ioctl_wr       (ioctl_wr)
	);

endmodule

`default_nettype wire

// File: hps_io_assertions.sv
`default_nettype none

module hps_io_assertions
	import hps_pkg::*;
(
	input logic     clk_sys,
	input logic     reset,
	input logic     io_enable,
	input io_word_t io_dout,
	input logic     ioctl_download,
	input logic     ioctl_wr
);

	int violations = 0;

	// a write pulse belongs to an open download
	wr_in_download: assert property (@(posedge clk_sys) disable iff (reset)
		ioctl_wr |-> ioctl_download)
	else begin
		violations = violations + 1;
		$error("ioctl_wr high while ioctl_download is low");
	end

	// write pulses are single cycle
	wr_single_cycle: assert property (@(posedge clk_sys) disable iff (reset)
		!(ioctl_wr && $past(ioctl_wr)))
	else begin
		violations = violations + 1;
		$error("ioctl_wr high for two cycles in a row");
	end

	// read-back clears once the frame has closed
	dout_cleared: assert property (@(posedge clk_sys) disable iff (reset)
		($past(io_enable, 2) && !$past(io_enable) && !io_enable) |-> (io_dout == '0))
	else begin
		violations = violations + 1;
		$error("io_dout not zero after io_enable went low");
	end

endmodule

`default_nettype wire

// File: tb_hps_io.sv
`default_nettype none

module tb_hps_io
	import hps_pkg::*;
;

	localparam int CLK_PERIOD      = 40;
	localparam int SEED            = 91711;
	// worst case is 75 frames of up to 33 words of 7 cycles each, plus the frame tail
	localparam int NUM_FRAMES      = 75;
	localparam int MAX_FRAME_WORDS = 33;
	localparam int WORD_CYCLES     = 7;
	localparam int TAIL_CYCLES     = 12;
	localparam int WATCHDOG_CYCLES =
		NUM_FRAMES * (MAX_FRAME_WORDS * WORD_CYCLES + TAIL_CYCLES) + 16 + 500;

	logic clk_sys = 1'b0;
	logic reset;
	logic io_enable;
	logic fp_enable;
	logic io_strobe;
	io_word_t io_din;
	io_word_t io_dout;
	status_t status_in;
	logic status_set;
	joy_t joystick_0;
	joy_t joystick_1;
	logic [1:0] buttons;
	logic forced_scandoubler;
	logic direct_video;
	status_t status;
	logic [10:0] ps2_key;
	logic ioctl_download;
	logic [7:0] ioctl_index;
	logic [31:0] ioctl_file_ext;
	logic [FILE_ADDR_W-1:0] ioctl_addr;
	logic [15:0] ioctl_dout;
	logic ioctl_wr;

	int checks = 0;
	int errors = 0;
	int wr_count = 0;
	io_word_t frame_q[$];
	io_word_t dout_q[$];
	io_word_t file_data[$];

	// model state
	io_word_t exp_cfg = '0;
	joy_t exp_joy0 = '0;
	joy_t exp_joy1 = '0;
	status_t exp_status = '0;
	status_t exp_req = '0;
	logic [3:0] exp_req_cnt = '0;
	logic [10:0] exp_key = '0;

	always #(CLK_PERIOD / 2) clk_sys = ~clk_sys;

	hps_io #(
		.WIDE (1)
	) i_hps_io (
		.clk_sys (clk_sys), .reset (reset),
		.io_enable (io_enable), .fp_enable (fp_enable),
		.io_strobe (io_strobe), .io_din (io_din), .io_dout (io_dout),
		.status_in (status_in), .status_set (status_set),
		.joystick_0 (joystick_0), .joystick_1 (joystick_1),
		.buttons (buttons), .forced_scandoubler (forced_scandoubler),
		.direct_video (direct_video), .status (status), .ps2_key (ps2_key),
		.ioctl_download (ioctl_download), .ioctl_index (ioctl_index),
		.ioctl_file_ext (ioctl_file_ext), .ioctl_addr (ioctl_addr),
		.ioctl_dout (ioctl_dout), .ioctl_wr (ioctl_wr)
	);

	bind hps_io hps_io_assertions u_assertions (
		.clk_sys (clk_sys), .reset (reset), .io_enable (io_enable),
		.io_dout (io_dout), .ioctl_download (ioctl_download), .ioctl_wr (ioctl_wr)
	);

	////////////////////////////////////////
	// helpers

	task automatic compare(input string name, input logic [63:0] got, input logic [63:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("mismatch %s: got %h expected %h", name, got, exp);
		end
	endtask

	task automatic end_test(input string name, input int errs_before);
		$display("test %s done, %0d errors", name, errors - errs_before);
	endtask

	task automatic start_frame(input io_word_t cmd);
		frame_q.delete();
		frame_q.push_back(cmd);
	endtask

	// sends frame_q on one enable and keeps io_dout after each strobe
	task automatic send_frame(input logic on_fp);
		int gap;
		dout_q.delete();
		if (on_fp)
			fp_enable = 1'b1;
		else
			io_enable = 1'b1;
		foreach (frame_q[i]) begin
			gap = $urandom_range(6, 3);
			repeat (gap) @(posedge clk_sys);
			#2;
			io_strobe = 1'b1;
			io_din = frame_q[i];
			@(posedge clk_sys);
			#2;
			io_strobe = 1'b0;
			dout_q.push_back(io_dout);
		end
		repeat (4) @(posedge clk_sys);
		#2;
		io_enable = 1'b0;
		fp_enable = 1'b0;
		repeat (5) @(posedge clk_sys);
		#2;
	endtask

	// scancode bytes to the 10-bit key field
	function automatic logic [9:0] key_code_of(input logic [31:0] raw);
		logic rel;
		logic ext;
		rel = (raw[15:8] == 8'hF0);
		ext = rel ? (raw[23:16] == 8'hE0) : (raw[15:8] == 8'hE0);
		if (raw == 32'hE012E07C)
			return 10'h37C;
		if (raw == 32'h7CE0F012)
			return 10'h17C;
		if (raw == 32'hF014F077)
			return 10'h377;
		return {~rel, ext, raw[7:0]};
	endfunction

	// each ioctl_wr pulse must carry the next file word
	always @(negedge clk_sys) begin
		if (!reset && ioctl_wr) begin
			if (wr_count >= file_data.size()) begin
				errors++;
				$display("ioctl_wr pulse with no file word left to write");
			end else begin
				compare("ioctl_download", 64'(ioctl_download), 64'd1);
				compare("ioctl_addr", 64'(ioctl_addr), 64'(2 * wr_count));
				compare("ioctl_dout", 64'(ioctl_dout), 64'(file_data[wr_count]));
			end
			wr_count++;
		end
	end

	initial begin
		#(WATCHDOG_CYCLES * CLK_PERIOD);
		$display("timeout: run did not finish within %0d cycles", WATCHDOG_CYCLES);
		$display("=== FAIL ===");
		$finish;
	end

	////////////////////////////////////////
	// test sequence
	initial begin
		int errs;
		int kind;
		int n;
		int pos;
		logic [63:0] val;
		logic [31:0] raw;
		logic skip;
		io_word_t w;
		logic [7:0] code;

		void'($urandom(SEED));
		reset = 1'b1;
		io_enable = 1'b0;
		fp_enable = 1'b0;
		io_strobe = 1'b0;
		io_din = '0;
		status_in = '0;
		status_set = 1'b0;
		repeat (16) @(posedge clk_sys);
		#2;
		reset = 1'b0;
		@(posedge clk_sys);
		#2;

		errs = errors;
		compare("io_dout", 64'(io_dout), 64'd0);
		compare("ps2_key", 64'(ps2_key), 64'd0);
		compare("status", status, 64'd0);
		compare("joystick_0", 64'(joystick_0), 64'd0);
		compare("joystick_1", 64'(joystick_1), 64'd0);
		compare("ioctl_download", 64'(ioctl_download), 64'd0);
		compare("ioctl_wr", 64'(ioctl_wr), 64'd0);
		end_test("reset", errs);

		// config word and joysticks
		errs = errors;
		repeat (20) begin
			kind = $urandom_range(2, 0);
			val[31:0] = $urandom();
			if (kind == 0) begin
				start_frame(CMD_CFG);
				frame_q.push_back(val[15:0]);
				exp_cfg = val[15:0];
			end else begin
				start_frame(kind == 1 ? CMD_JOY0 : CMD_JOY1);
				frame_q.push_back(val[15:0]);
				frame_q.push_back(val[31:16]);
				if (kind == 1)
					exp_joy0 = val[31:0];
				else
					exp_joy1 = val[31:0];
			end
			send_frame(1'b0);
			compare("buttons", 64'(buttons), 64'(exp_cfg[1:0]));
			compare("forced_scandoubler", 64'(forced_scandoubler), 64'(exp_cfg[4]));
			compare("direct_video", 64'(direct_video), 64'(exp_cfg[10]));
			compare("joystick_0", 64'(joystick_0), 64'(exp_joy0));
			compare("joystick_1", 64'(joystick_1), 64'(exp_joy1));
		end
		end_test("config_joystick", errs);

		errs = errors;
		repeat (8) begin
			val = {$urandom(), $urandom()};
			start_frame(CMD_STATUS);
			for (int q = 0; q < 4; q++)
				frame_q.push_back(val[q*16 +: 16]);
			exp_status = val;
			send_frame(1'b0);
			compare("status", status, exp_status);
		end
		end_test("status", errs);

		// status-set requests, then host read-back
		errs = errors;
		n = $urandom_range(20, 1);
		repeat (n) begin
			val = {$urandom(), $urandom()};
			status_in = val;
			status_set = 1'b1;
			@(posedge clk_sys);
			#2;
			status_set = 1'b0;
			repeat (2) @(posedge clk_sys);
			#2;
			exp_req = val;
			exp_req_cnt = exp_req_cnt + 4'd1;
		end
		start_frame(CMD_STATUS_REQ);
		repeat (4) frame_q.push_back(16'h0000);
		send_frame(1'b0);
		compare("io_dout", 64'(dout_q[0]), 64'({8'h00, 4'hA, exp_req_cnt}));
		for (int q = 1; q <= 4; q++)
			compare("io_dout", 64'(dout_q[q]), 64'(exp_req[(q-1)*16 +: 16]));
		compare("io_dout", 64'(io_dout), 64'd0);
		end_test("status_request", errs);

		errs = errors;
		repeat (40) begin
			kind = $urandom_range(7, 0);
			code = 8'($urandom_range(8'h7E, 8'h01));
			start_frame(CMD_KBD);
			case (kind)
				1: frame_q.push_back(16'h00F0);
				2: frame_q.push_back(16'h00E0);
				3: begin
					frame_q.push_back(16'h00E0);
					frame_q.push_back(16'h00F0);
				end
				default: ;
			endcase
			case (kind)
				// print screen make and break, pause
				4: begin
					frame_q.push_back(16'h00E0);
					frame_q.push_back(16'h0012);
					frame_q.push_back(16'h00E0);
					frame_q.push_back(16'h007C);
				end
				5: begin
					frame_q.push_back(16'h00E0);
					frame_q.push_back(16'h00F0);
					frame_q.push_back(16'h007C);
					frame_q.push_back(16'h00E0);
					frame_q.push_back(16'h00F0);
					frame_q.push_back(16'h0012);
				end
				6: begin
					frame_q.push_back(16'h00E1);
					frame_q.push_back(16'h0014);
					frame_q.push_back(16'h0077);
					frame_q.push_back(16'h00E1);
					frame_q.push_back(16'h00F0);
					frame_q.push_back(16'h0014);
					frame_q.push_back(16'h00F0);
					frame_q.push_back(16'h0077);
				end
				default: frame_q.push_back({8'h00, code});
			endcase
			if (kind == 7) begin
				pos = $urandom_range(frame_q.size(), 1);
				frame_q.insert(pos, {KEY_SKIP_BYTE, 8'($urandom())});
			end
			raw = '0;
			skip = 1'b0;
			for (int i = 1; i < frame_q.size(); i++) begin
				if (frame_q[i][15:8] == 8'hFF)
					skip = 1'b1;
				else if (!skip)
					raw = {raw[23:0], frame_q[i][7:0]};
			end
			if (!skip)
				exp_key = {~exp_key[10], key_code_of(raw)};
			send_frame(1'b0);
			compare("ps2_key", 64'(ps2_key), 64'(exp_key));
		end
		end_test("keyboard", errs);

		// file download with 16-bit words
		errs = errors;
		w = 16'($urandom_range(255, 0));
		start_frame(CMD_FILE_INDEX);
		frame_q.push_back(w);
		send_frame(1'b1);
		compare("ioctl_index", 64'(ioctl_index), 64'(w[7:0]));
		val[31:0] = $urandom();
		start_frame(CMD_FILE_INFO);
		frame_q.push_back(val[31:16]);
		frame_q.push_back(val[15:0]);
		send_frame(1'b1);
		compare("ioctl_file_ext", 64'(ioctl_file_ext), 64'(val[31:0]));
		start_frame(CMD_FILE_TX);
		frame_q.push_back(16'h0001);
		send_frame(1'b1);
		compare("ioctl_download", 64'(ioctl_download), 64'd1);
		n = $urandom_range(MAX_FRAME_WORDS - 1, 16);
		file_data.delete();
		wr_count = 0;
		start_frame(CMD_FILE_TX_DAT);
		repeat (n) begin
			w = 16'($urandom());
			file_data.push_back(w);
			frame_q.push_back(w);
		end
		send_frame(1'b1);
		start_frame(CMD_FILE_TX);
		frame_q.push_back(16'h0000);
		send_frame(1'b1);
		compare("ioctl_wr count", 64'(wr_count), 64'(n));
		compare("ioctl_addr", 64'(ioctl_addr), 64'(2 * n));
		compare("ioctl_download", 64'(ioctl_download), 64'd0);
		end_test("file_download", errs);

		$display("checks %0d, errors %0d, assertion failures %0d", checks, errors,
			i_hps_io.u_assertions.violations);
		if (errors == 0 && i_hps_io.u_assertions.violations == 0) begin
			$display("=== PASS ===");
		end else begin
			$display("=== FAIL ===");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: sim.f
hps_pkg.sv
hps_cmd_frame.sv
hps_input_regs.sv
hps_key_decode.sv
hps_file_loader.sv
hps_io.sv
hps_io_assertions.sv
tb_hps_io.sv

// File: run_sim.sh
#!/bin/sh
# compile and run the hps_io testbench with Verilator

cd "$(dirname "$0")" || exit 1

rm -rf obj_dir sim.log

verilator --binary --timing --assert --top-module tb_hps_io -f sim.f -o tb_hps_io
if [ $? -ne 0 ]; then
	echo "build failed"
	exit 1
fi

./obj_dir/tb_hps_io +verilator+error+limit+1000 > sim.log 2>&1
run_status=$?
cat sim.log
if [ $run_status -ne 0 ]; then
	echo "simulation exited with status $run_status"
	exit 1
fi

if grep -qx "=== PASS ===" sim.log; then
	exit 0
fi
exit 1
